// File: include/frame_tx_settings.svh
`ifndef FRAME_TX_SETTINGS_SVH
`define FRAME_TX_SETTINGS_SVH

// ----------------------------------------
// Frame layout
// ----------------------------------------

// Ethernet + IPv4 + TCP, no options
`define FTX_HDR_BYTES 54

// Whole words ahead of the boundary word
`define FTX_HDR_WORDS 13

`define FTX_IP_HDR_BYTES 20
`define FTX_TCP_HDR_BYTES 20

// ----------------------------------------
// Protocol values and limits
// ----------------------------------------

`define FTX_ETHERTYPE_IPV4 16'h0800
`define FTX_IP_PROTO_TCP 8'd6

// Largest payload that fits a standard MTU
`define FTX_MAX_PAYLOAD 1460

`endif

// File: logic/frame_tx_pkg.sv
`default_nettype none

package frame_tx_pkg;

	// ----------------------------------------
	// Stream and field widths
	// ----------------------------------------

	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [31:0] seq_num_t;
	typedef logic [15:0] len_t;

	// Enough for the longest frame (379 words)
	typedef logic [9:0] word_idx_t;

	// Valid bytes in the last word, 0 means all four
	typedef logic [1:0] be_t;

	typedef logic [5:0] tcp_flags_t;

	// ----------------------------------------
	// Sequencer states
	// ----------------------------------------

	typedef enum logic [0:0] {
		SEQ_IDLE,
		SEQ_SEND
	} seq_state_t;

endpackage

`default_nettype wire

// File: logic/tx_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tx_ctrl_if
	import frame_tx_pkg::*;
();

	// Pulse on an accepted idle start
	logic      load;
	logic      busy;
	word_idx_t word_idx;

	// Word on the output taken by the consumer
	logic      advance;

	// Same acceptance also consumes a payload word
	logic      pop;

	modport seq (
		output load, busy, word_idx, advance, pop
	);

	modport dst (
		input load, busy, word_idx, advance, pop
	);

endinterface

`default_nettype wire

// File: logic/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "frame_tx_settings.svh"

module frame_sequencer
	import frame_tx_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   start,
	input  logic   data_out_rd,
	input  len_t   payload_len,
	tx_ctrl_if.seq ctrl,
	output logic   sop,
	output logic   eop,
	output logic   data_out_rdy,
	output be_t    be_out
);

	localparam word_idx_t BOUNDARY_IDX = word_idx_t'(`FTX_HDR_WORDS);

	seq_state_t state;
	word_idx_t  word_idx;
	word_idx_t  last_idx;
	word_idx_t  pop_total;
	word_idx_t  pop_cnt;
	be_t        be_code;
	len_t       frame_bytes;
	len_t       last_sum;
	len_t       pop_sum;
	logic       last_word;
	logic       payload_left;

	// Frame geometry from the requested length
	assign frame_bytes = payload_len + len_t'(`FTX_HDR_BYTES);
	assign last_sum    = frame_bytes + 16'd3;
	assign pop_sum     = payload_len + 16'd3;

	// ----------------------------------------
	// Handshake towards the word producers
	// ----------------------------------------

	assign ctrl.load     = (state == SEQ_IDLE) && start;
	assign ctrl.busy     = (state == SEQ_SEND);
	assign ctrl.advance  = ctrl.busy && data_out_rd;
	assign ctrl.word_idx = word_idx;

	// First pop at the boundary word, then one per word until drained
	assign payload_left = (word_idx >= BOUNDARY_IDX) && (pop_cnt != pop_total);
	assign ctrl.pop     = ctrl.advance && payload_left;

	assign last_word = (word_idx == last_idx);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
		end else if (ctrl.load) begin
			state <= SEQ_SEND;
		end else if (ctrl.advance && last_word) begin
			state <= SEQ_IDLE;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word_idx <= '0;
			pop_cnt  <= '0;
		end else if (ctrl.load) begin
			word_idx <= '0;
			pop_cnt  <= '0;
		end else begin
			if (ctrl.advance)
				word_idx <= word_idx + 10'd1;
			if (ctrl.pop)
				pop_cnt <= pop_cnt + 10'd1;
		end
	end

	// Held for the whole frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_idx  <= '0;
			pop_total <= '0;
			be_code   <= '0;
		end else if (ctrl.load) begin
			last_idx  <= last_sum[11:2] - 10'd1;
			pop_total <= pop_sum[11:2];
			be_code   <= frame_bytes[1:0];
		end
	end

	// ----------------------------------------
	// Frame marks
	// ----------------------------------------

	assign sop          = ctrl.busy && (word_idx == '0);
	assign eop          = ctrl.busy && last_word;
	assign be_out       = eop ? be_code : '0;
	assign data_out_rdy = ctrl.busy;

	// Index never runs past the last word of the frame
	a_adv_send: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.advance |-> word_idx <= last_idx);

	// Every payload word is consumed by the time the last word leaves
	a_pop_adv: assert property (@(posedge clk) disable iff (!rst_n)
		(ctrl.advance && last_word) |-> (pop_cnt + 10'(ctrl.pop)) == pop_total);

	// Each frame opens with sop and never with eop
	a_marks_busy: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.load |=> sop && !eop);

	// Source must request a length the frame can carry
	a_len_range: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.load |-> (payload_len != '0) && (payload_len <= len_t'(`FTX_MAX_PAYLOAD)));

endmodule

`default_nettype wire

// File: logic/header_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "frame_tx_settings.svh"

module header_builder
	import frame_tx_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	tx_ctrl_if.dst      ctrl,
	input  mac_addr_t   mac_dst_addr,
	input  mac_addr_t   mac_src_addr,
	input  logic [7:0]  ip_dsf,
	input  half_t       ip_id,
	input  logic [2:0]  ip_flags,
	input  logic [12:0] ip_frag_offset,
	input  logic [7:0]  ip_ttl,
	input  ip_addr_t    ip_src_addr,
	input  ip_addr_t    ip_dst_addr,
	input  half_t       tcp_src_port,
	input  half_t       tcp_dst_port,
	input  seq_num_t    tcp_seq_num,
	input  seq_num_t    tcp_ack_num,
	input  tcp_flags_t  tcp_flags,
	input  half_t       tcp_window,
	input  half_t       tcp_urgent_ptr,
	input  len_t        payload_len,
	input  half_t       payload_sum,
	output word_t       hdr_word
);

	localparam logic [3:0] IP_VERSION = 4'd4;
	localparam logic [3:0] IP_IHL     = 4'(`FTX_IP_HDR_BYTES / 4);
	localparam logic [3:0] TCP_DOFF   = 4'(`FTX_TCP_HDR_BYTES / 4);
	localparam logic [7:0] IP_PROTO   = `FTX_IP_PROTO_TCP;
	localparam half_t      ETHERTYPE  = `FTX_ETHERTYPE_IPV4;

	mac_addr_t   mac_dst_r;
	mac_addr_t   mac_src_r;
	logic [7:0]  ip_dsf_r;
	half_t       ip_id_r;
	logic [2:0]  ip_flags_r;
	logic [12:0] ip_frag_r;
	logic [7:0]  ip_ttl_r;
	ip_addr_t    ip_src_r;
	ip_addr_t    ip_dst_r;
	len_t        ip_total_r;
	len_t        tcp_len_r;
	half_t       tcp_sport_r;
	half_t       tcp_dport_r;
	seq_num_t    tcp_seq_r;
	seq_num_t    tcp_ack_r;
	tcp_flags_t  tcp_flags_r;
	half_t       tcp_window_r;
	half_t       tcp_urg_r;
	half_t       payload_sum_r;

	logic        sum_en;
	logic        fold_en;
	word_t       ip_raw;
	word_t       tcp_raw;
	logic [16:0] ip_fold1;
	logic [16:0] tcp_fold1;
	half_t       ip_fold2;
	half_t       tcp_fold2;
	half_t       ip_chk;
	half_t       tcp_chk;

	// ----------------------------------------
	// Field capture
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (ctrl.load) begin
			mac_dst_r     <= mac_dst_addr;
			mac_src_r     <= mac_src_addr;
			ip_dsf_r      <= ip_dsf;
			ip_id_r       <= ip_id;
			ip_flags_r    <= ip_flags;
			ip_frag_r     <= ip_frag_offset;
			ip_ttl_r      <= ip_ttl;
			ip_src_r      <= ip_src_addr;
			ip_dst_r      <= ip_dst_addr;
			ip_total_r    <= payload_len + len_t'(`FTX_IP_HDR_BYTES + `FTX_TCP_HDR_BYTES);
			tcp_len_r     <= payload_len + len_t'(`FTX_TCP_HDR_BYTES);
			tcp_sport_r   <= tcp_src_port;
			tcp_dport_r   <= tcp_dst_port;
			tcp_seq_r     <= tcp_seq_num;
			tcp_ack_r     <= tcp_ack_num;
			tcp_flags_r   <= tcp_flags;
			tcp_window_r  <= tcp_window;
			tcp_urg_r     <= tcp_urgent_ptr;
			payload_sum_r <= payload_sum;
		end
	end

	// ----------------------------------------
	// Checksums
	// ----------------------------------------

	// Sums on 32 bits, carries folded back below
	assign ip_raw = {IP_VERSION, IP_IHL, ip_dsf_r} + ip_total_r + ip_id_r
		+ {ip_flags_r, ip_frag_r} + {ip_ttl_r, IP_PROTO}
		+ ip_src_r[31:16] + ip_src_r[15:0] + ip_dst_r[31:16] + ip_dst_r[15:0];

	// Pseudo header, TCP header, then the payload sum from the source
	assign tcp_raw = ip_src_r[31:16] + ip_src_r[15:0] + ip_dst_r[31:16] + ip_dst_r[15:0]
		+ {8'd0, IP_PROTO} + tcp_len_r
		+ tcp_sport_r + tcp_dport_r
		+ tcp_seq_r[31:16] + tcp_seq_r[15:0] + tcp_ack_r[31:16] + tcp_ack_r[15:0]
		+ {TCP_DOFF, 6'd0, tcp_flags_r} + tcp_window_r + tcp_urg_r
		+ payload_sum_r;

	assign ip_fold2  = ip_fold1[15:0] + 16'(ip_fold1[16]);
	assign tcp_fold2 = tcp_fold1[15:0] + 16'(tcp_fold1[16]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum_en  <= 1'b0;
			fold_en <= 1'b0;
		end else begin
			sum_en  <= ctrl.load;
			fold_en <= sum_en;
		end
	end

	always_ff @(posedge clk) begin
		if (sum_en) begin
			ip_fold1  <= {1'b0, ip_raw[31:16]} + {1'b0, ip_raw[15:0]};
			tcp_fold1 <= {1'b0, tcp_raw[31:16]} + {1'b0, tcp_raw[15:0]};
		end
		if (fold_en) begin
			ip_chk  <= ~ip_fold2;
			tcp_chk <= ~tcp_fold2;
		end
	end

	// ----------------------------------------
	// Header word select
	// ----------------------------------------

	always_comb begin
		case (ctrl.word_idx)
			10'd0:   hdr_word = mac_dst_r[47:16];
			10'd1:   hdr_word = {mac_dst_r[15:0], mac_src_r[47:32]};
			10'd2:   hdr_word = mac_src_r[31:0];
			10'd3:   hdr_word = {ETHERTYPE, IP_VERSION, IP_IHL, ip_dsf_r};
			10'd4:   hdr_word = {ip_total_r, ip_id_r};
			10'd5:   hdr_word = {ip_flags_r, ip_frag_r, ip_ttl_r, IP_PROTO};
			10'd6:   hdr_word = {ip_chk, ip_src_r[31:16]};
			10'd7:   hdr_word = {ip_src_r[15:0], ip_dst_r[31:16]};
			10'd8:   hdr_word = {ip_dst_r[15:0], tcp_sport_r};
			10'd9:   hdr_word = {tcp_dport_r, tcp_seq_r[31:16]};
			10'd10:  hdr_word = {tcp_seq_r[15:0], tcp_ack_r[31:16]};
			10'd11:  hdr_word = {tcp_ack_r[15:0], TCP_DOFF, 6'd0, tcp_flags_r};
			10'd12:  hdr_word = {tcp_window_r, tcp_chk};
			10'd13:  hdr_word = {tcp_urg_r, 16'h0000};
			default: hdr_word = '0;
		endcase
	end

	a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.load |-> !ctrl.busy);

	// Both checksums settled before the IP checksum word goes out
	a_chk_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(ctrl.busy && ctrl.word_idx >= 10'd6) |-> !sum_en && !fold_en);

endmodule

`default_nettype wire

// File: logic/payload_aligner.sv
`timescale 1ns/1ps
`default_nettype none

`include "frame_tx_settings.svh"

module payload_aligner
	import frame_tx_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	tx_ctrl_if.dst ctrl,
	input  word_t  hdr_word,
	input  word_t  data_in,
	output word_t  data_out
);

	localparam word_idx_t BOUNDARY_IDX = word_idx_t'(`FTX_HDR_WORDS);

	// Low half of the last popped word, sent ahead of the next one
	half_t carry;

	always_ff @(posedge clk) begin
		if (ctrl.load) begin
			carry <= '0;
		end else if (ctrl.pop) begin
			carry <= data_in[15:0];
		end
	end

	// ----------------------------------------
	// Output word
	// ----------------------------------------

	// Ethernet header leaves payload two bytes off word alignment
	always_comb begin
		if (ctrl.word_idx < BOUNDARY_IDX) begin
			data_out = hdr_word;
		end else if (ctrl.word_idx == BOUNDARY_IDX) begin
			// Urgent pointer, then first two payload bytes
			data_out = {hdr_word[31:16], data_in[31:16]};
		end else begin
			data_out = {carry, data_in[31:16]};
		end
	end

	a_pop_payload: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.pop |-> ctrl.word_idx >= BOUNDARY_IDX);

endmodule

`default_nettype wire

// File: logic/frame_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_tx_top
	import frame_tx_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        start,

	// Header fields, sampled on an idle start
	input  mac_addr_t   mac_dst_addr,
	input  mac_addr_t   mac_src_addr,
	input  logic [7:0]  ip_dsf,
	input  half_t       ip_id,
	input  logic [2:0]  ip_flags,
	input  logic [12:0] ip_frag_offset,
	input  logic [7:0]  ip_ttl,
	input  ip_addr_t    ip_src_addr,
	input  ip_addr_t    ip_dst_addr,
	input  half_t       tcp_src_port,
	input  half_t       tcp_dst_port,
	input  seq_num_t    tcp_seq_num,
	input  seq_num_t    tcp_ack_num,
	input  tcp_flags_t  tcp_flags,
	input  half_t       tcp_window,
	input  half_t       tcp_urgent_ptr,
	input  len_t        payload_len,
	input  half_t       payload_sum,

	// Frame stream out
	output word_t       data_out,
	output be_t         be_out,
	output logic        data_out_rdy,
	input  logic        data_out_rd,
	output logic        sop,
	output logic        eop,

	// Payload source, first word falls through
	input  word_t       data_in,
	output logic        data_in_rd,

	output logic        busy
);

	word_t hdr_word;

	tx_ctrl_if ctrl ();

	assign data_in_rd = ctrl.pop;
	assign busy       = ctrl.busy;

	frame_sequencer u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.data_out_rd  (data_out_rd),
		.payload_len  (payload_len),
		.ctrl         (ctrl.seq),
		.sop          (sop),
		.eop          (eop),
		.data_out_rdy (data_out_rdy),
		.be_out       (be_out)
	);

	header_builder u_hdr (
		.clk            (clk),
		.rst_n          (rst_n),
		.ctrl           (ctrl.dst),
		.mac_dst_addr   (mac_dst_addr),
		.mac_src_addr   (mac_src_addr),
		.ip_dsf         (ip_dsf),
		.ip_id          (ip_id),
		.ip_flags       (ip_flags),
		.ip_frag_offset (ip_frag_offset),
		.ip_ttl         (ip_ttl),
		.ip_src_addr    (ip_src_addr),
		.ip_dst_addr    (ip_dst_addr),
		.tcp_src_port   (tcp_src_port),
		.tcp_dst_port   (tcp_dst_port),
		.tcp_seq_num    (tcp_seq_num),
		.tcp_ack_num    (tcp_ack_num),
		.tcp_flags      (tcp_flags),
		.tcp_window     (tcp_window),
		.tcp_urgent_ptr (tcp_urgent_ptr),
		.payload_len    (payload_len),
		.payload_sum    (payload_sum),
		.hdr_word       (hdr_word)
	);

	payload_aligner u_align (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl     (ctrl.dst),
		.hdr_word (hdr_word),
		.data_in  (data_in),
		.data_out (data_out)
	);

endmodule

`default_nettype wire

// File: sim/frame_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "frame_tx_settings.svh"

module frame_tx_tb
	import frame_tx_pkg::*;
();

	localparam int NUM_FRAMES  = 41;
	localparam int MAX_WORDS   = (`FTX_HDR_BYTES + `FTX_MAX_PAYLOAD + 3) / 4;
	localparam int CYCLE_LIMIT = NUM_FRAMES * MAX_WORDS * 4 + 1000;
	localparam int FRAME_MAX   = `FTX_HDR_BYTES + `FTX_MAX_PAYLOAD + 4;
	localparam int PAY_MAX     = `FTX_MAX_PAYLOAD + 4;

	logic        clk;
	logic        rst_n;
	logic        start;
	mac_addr_t   mac_dst_addr;
	mac_addr_t   mac_src_addr;
	logic [7:0]  ip_dsf;
	half_t       ip_id;
	logic [2:0]  ip_flags;
	logic [12:0] ip_frag_offset;
	logic [7:0]  ip_ttl;
	ip_addr_t    ip_src_addr;
	ip_addr_t    ip_dst_addr;
	half_t       tcp_src_port;
	half_t       tcp_dst_port;
	seq_num_t    tcp_seq_num;
	seq_num_t    tcp_ack_num;
	tcp_flags_t  tcp_flags;
	half_t       tcp_window;
	half_t       tcp_urgent_ptr;
	len_t        payload_len;
	half_t       payload_sum;
	word_t       data_out;
	be_t         be_out;
	logic        data_out_rdy;
	logic        data_out_rd;
	logic        sop;
	logic        eop;
	word_t       data_in;
	logic        data_in_rd;
	logic        busy;

	integer      seed;
	int          cycles = 0;
	logic [7:0]  exp_bytes [FRAME_MAX];
	logic [7:0]  pay_bytes [PAY_MAX];

	frame_tx_top UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.start          (start),
		.mac_dst_addr   (mac_dst_addr),
		.mac_src_addr   (mac_src_addr),
		.ip_dsf         (ip_dsf),
		.ip_id          (ip_id),
		.ip_flags       (ip_flags),
		.ip_frag_offset (ip_frag_offset),
		.ip_ttl         (ip_ttl),
		.ip_src_addr    (ip_src_addr),
		.ip_dst_addr    (ip_dst_addr),
		.tcp_src_port   (tcp_src_port),
		.tcp_dst_port   (tcp_dst_port),
		.tcp_seq_num    (tcp_seq_num),
		.tcp_ack_num    (tcp_ack_num),
		.tcp_flags      (tcp_flags),
		.tcp_window     (tcp_window),
		.tcp_urgent_ptr (tcp_urgent_ptr),
		.payload_len    (payload_len),
		.payload_sum    (payload_sum),
		.data_out       (data_out),
		.be_out         (be_out),
		.data_out_rdy   (data_out_rdy),
		.data_out_rd    (data_out_rd),
		.sop            (sop),
		.eop            (eop),
		.data_in        (data_in),
		.data_in_rd     (data_in_rd),
		.busy           (busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run timed out after %0d cycles without finishing all frames", cycles);
			$display("SIMULATION FAILED");
			$fatal(1, "Timeout");
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s actual=%h expected=%h", $time, name, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % n;
	endfunction

	task automatic set_fields();
		mac_dst_addr   = {16'($random(seed)), 32'($random(seed))};
		mac_src_addr   = {16'($random(seed)), 32'($random(seed))};
		ip_dsf         = 8'($random(seed));
		ip_id          = 16'($random(seed));
		ip_flags       = 3'($random(seed));
		ip_frag_offset = 13'($random(seed));
		ip_ttl         = 8'($random(seed));
		ip_src_addr    = $random(seed);
		ip_dst_addr    = $random(seed);
		tcp_src_port   = 16'($random(seed));
		tcp_dst_port   = 16'($random(seed));
		tcp_seq_num    = $random(seed);
		tcp_ack_num    = $random(seed);
		tcp_flags      = 6'($random(seed));
		tcp_window     = 16'($random(seed));
		tcp_urgent_ptr = 16'($random(seed));
	endtask

	task automatic put_half(input int pos, input logic [15:0] v);
		exp_bytes[pos]     = v[15:8];
		exp_bytes[pos + 1] = v[7:0];
	endtask

	task automatic put_word(input int pos, input logic [31:0] v);
		put_half(pos, v[31:16]);
		put_half(pos + 2, v[15:0]);
	endtask

	// Big-endian 16-bit sum with a zero-padded odd tail
	function automatic logic [31:0] word_sum(input int first, input int count);
		logic [31:0] acc;
		int          i;
		acc = '0;
		for (i = 0; i < count; i += 2)
			acc += {exp_bytes[first + i], (i + 1 < count) ? exp_bytes[first + i + 1] : 8'h00};
		return acc;
	endfunction

	function automatic half_t fold_sum(input logic [31:0] s);
		logic [31:0] acc;
		acc = s;
		while (acc[31:16] != 16'd0)
			acc = acc[31:16] + acc[15:0];
		return acc[15:0];
	endfunction

	function automatic word_t source_word(input int p);
		return {pay_bytes[4 * p], pay_bytes[4 * p + 1], pay_bytes[4 * p + 2],
			pay_bytes[4 * p + 3]};
	endfunction

	// ----------------------------------------
	// Reference frame
	// ----------------------------------------

	task automatic build_frame(input int len);
		logic [31:0] pseudo;
		int          i;
		for (i = 0; i < FRAME_MAX; i++)
			exp_bytes[i] = 8'h00;
		put_half(0, mac_dst_addr[47:32]);
		put_word(2, mac_dst_addr[31:0]);
		put_half(6, mac_src_addr[47:32]);
		put_word(8, mac_src_addr[31:0]);
		put_half(12, 16'h0800);
		exp_bytes[14] = 8'h45;
		exp_bytes[15] = ip_dsf;
		put_half(16, 16'(len + 40));
		put_half(18, ip_id);
		put_half(20, {ip_flags, ip_frag_offset});
		exp_bytes[22] = ip_ttl;
		exp_bytes[23] = 8'd6;
		put_word(26, ip_src_addr);
		put_word(30, ip_dst_addr);
		put_half(34, tcp_src_port);
		put_half(36, tcp_dst_port);
		put_word(38, tcp_seq_num);
		put_word(42, tcp_ack_num);
		put_half(46, {4'd5, 6'd0, tcp_flags});
		put_half(48, tcp_window);
		put_half(52, tcp_urgent_ptr);
		for (i = 0; i < len; i++)
			exp_bytes[54 + i] = pay_bytes[i];
		// Checksum fields are still zero here
		put_half(24, ~fold_sum(word_sum(14, 20)));
		pseudo = ip_src_addr[31:16] + ip_src_addr[15:0] + ip_dst_addr[31:16]
			+ ip_dst_addr[15:0] + 32'd6 + 32'(len + 20);
		put_half(50, ~fold_sum(pseudo + word_sum(34, 20 + len)));
	endtask

	// ----------------------------------------
	// One frame entered and left 1 ns after a rising edge
	// ----------------------------------------

	task automatic send_frame(input int len);
		int    num_words;
		int    num_pops;
		int    idx;
		int    pops;
		int    rd_ptr;
		int    i;
		logic  popped;
		logic  last;
		be_t   exp_be;
		word_t mask;
		word_t exp_word;
		num_words = (54 + len + 3) / 4;
		num_pops  = (len + 3) / 4;
		exp_be    = be_t'((54 + len) % 4);
		case (exp_be)
			2'd1:    mask = 32'hff00_0000;
			2'd2:    mask = 32'hffff_0000;
			2'd3:    mask = 32'hffff_ff00;
			default: mask = 32'hffff_ffff;
		endcase
		set_fields();
		for (i = 0; i < PAY_MAX; i++)
			pay_bytes[i] = 8'($random(seed));
		build_frame(len);
		payload_len = len_t'(len);
		payload_sum = fold_sum(word_sum(54, len));
		rd_ptr      = 0;
		data_in     = source_word(0);
		start       = 1'b1;
		data_out_rd = rand_below(100) < 70;
		@(negedge clk);
		check("busy", busy, 0);
		check("data_out_rdy", data_out_rdy, 0);
		check("sop", sop, 0);
		@(posedge clk);
		#1;
		start = 1'b0;
		idx   = 0;
		pops  = 0;
		last  = 1'b0;
		while (!last) begin
			@(negedge clk);
			check("busy", busy, 1);
			check("data_out_rdy", data_out_rdy, 1);
			check("sop", sop, idx == 0);
			check("eop", eop, idx == num_words - 1);
			check("be_out", be_out, (idx == num_words - 1) ? exp_be : 2'd0);
			popped = data_out_rd && (idx >= 13) && (pops < num_pops);
			check("data_in_rd", data_in_rd, popped);
			if (data_out_rd) begin
				exp_word = {exp_bytes[4 * idx], exp_bytes[4 * idx + 1],
					exp_bytes[4 * idx + 2], exp_bytes[4 * idx + 3]};
				last = (idx == num_words - 1);
				if (last)
					check("data_out", data_out & mask, exp_word & mask);
				else
					check("data_out", data_out, exp_word);
				idx++;
			end
			if (data_in_rd)
				pops++;
			@(posedge clk);
			#1;
			// FWFT source moves on after a read
			if (popped) begin
				rd_ptr++;
				data_in = source_word(rd_ptr);
			end
			data_out_rd = rand_below(100) < 70;
			// Stray start and new fields while the frame is in flight
			if (!last && rand_below(100) < 10) begin
				start = 1'b1;
				set_fields();
				payload_len = len_t'(rand_below(64) + 1);
				payload_sum = 16'($random(seed));
			end else begin
				start = 1'b0;
			end
		end
		@(negedge clk);
		check("busy", busy, 0);
		check("data_out_rdy", data_out_rdy, 0);
		check("eop", eop, 0);
		@(posedge clk);
		#1;
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin
		int f;
		int len;
		int gap;
		seed        = 86226;
		rst_n       = 1'b0;
		start       = 1'b0;
		data_out_rd = 1'b0;
		data_in     = '0;
		payload_len = 16'd1;
		payload_sum = '0;
		set_fields();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check("data_out_rdy", data_out_rdy, 0);
		check("busy", busy, 0);
		check("sop", sop, 0);
		check("eop", eop, 0);
		check("data_in_rd", data_in_rd, 0);
		@(posedge clk);
		#1;
		// Short frames covering every residue of the length mod 4
		for (f = 0; f < NUM_FRAMES - 1; f++) begin
			len = 4 * rand_below(16) + (f % 4) + 1;
			send_frame(len);
			gap = rand_below(3);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
		send_frame(`FTX_MAX_PAYLOAD);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
logic/frame_tx_pkg.sv
logic/tx_ctrl_if.sv
logic/frame_sequencer.sv
logic/header_builder.sv
logic/payload_aligner.sv
logic/frame_tx_top.sv
sim/frame_tx_tb.sv
